// ==== verilog/gw_cfg_pkg.sv ====
package gw_cfg_pkg;

  //////////////////////////////
  // Tag payload layout
  //////////////////////////////

  // Node coordinate, as carried in memory packets
  localparam int CORD_WIDTH = 7;

  // Both tag clients shift this many bits
  localparam int TAG_PAYLOAD_WIDTH = 8;

  // Control client holds the node reset and own coordinate
  typedef struct packed {
    logic                  reset;
    logic [CORD_WIDTH-1:0] cord;
  } gw_ctl_payload_s;

  // Map client holds the first page that belongs to DRAM
  typedef struct packed {
    logic [TAG_PAYLOAD_WIDTH-1:0] base_page;
  } gw_map_payload_s;

  // Node comes up held in reset until the control tag clears it
  localparam gw_ctl_payload_s GW_CTL_DEFAULT = '{
    reset: 1'b1,
    cord:  '0
  };

  localparam gw_map_payload_s GW_MAP_DEFAULT = '{
    base_page: 8'h80
  };

endpackage

// ==== verilog/gw_mem_pkg.sv ====
package gw_mem_pkg;

  import gw_cfg_pkg::*;

  localparam int ADDR_WIDTH = 20;
  localparam int DATA_WIDTH = 32;

  // Upper address bits compared against the base page
  localparam int PAGE_WIDTH = 8;

  // Targets index their word arrays with the low address bits
  localparam int DRAM_WORDS      = 256;
  localparam int DRAM_IDX_WIDTH  = $clog2(DRAM_WORDS);
  localparam int HOST_REGS       = 4;
  localparam int HOST_IDX_WIDTH  = $clog2(HOST_REGS);
  localparam int HOST_FINISH_REG = 3;

  typedef enum logic {
    GW_OP_READ  = 1'b0,
    GW_OP_WRITE = 1'b1
  } gw_mem_op_e;

  typedef struct packed {
    gw_mem_op_e            op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [CORD_WIDTH-1:0] src_cord;
  } gw_mem_cmd_s;

  typedef struct packed {
    gw_mem_op_e            op;
    logic [DATA_WIDTH-1:0] data;
    logic [CORD_WIDTH-1:0] dst_cord;
    logic [CORD_WIDTH-1:0] src_cord;
  } gw_mem_resp_s;

endpackage

// ==== verilog/gw_mem_if.sv ====
`timescale 1ns/100ps

interface gw_mem_if
  import gw_mem_pkg::*;
();

  // Command channel with valid/yumi handshake
  logic         cmd_v;
  gw_mem_cmd_s  cmd;
  logic         cmd_yumi;

  // Response channel with valid/ready handshake
  logic         resp_v;
  gw_mem_resp_s resp;
  logic         resp_ready;

  modport requester (
    output cmd_v, cmd, resp_ready,
    input  cmd_yumi, resp_v, resp
  );

  modport target (
    input  cmd_v, cmd, resp_ready,
    output cmd_yumi, resp_v, resp
  );

endinterface

// ==== verilog/gw_tag_client.sv ====
`timescale 1ns/100ps

module gw_tag_client #(
  parameter type      payload_t = logic [7:0],
  parameter payload_t DEFAULT   = payload_t'(0)
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     en_i,
  input  logic     data_i,
  output payload_t payload_o,
  output logic     new_o
);

  localparam int WIDTH     = $bits(payload_t);
  localparam int CNT_WIDTH = $clog2(WIDTH + 1);

  logic [WIDTH-1:0]     shift_r;
  logic [CNT_WIDTH-1:0] count_r;
  logic                 full;

  assign full = (count_r == CNT_WIDTH'(WIDTH));

  // LSB first so the first bit ends up in bit 0
  always_ff @(posedge clk_i)
  begin
    if (en_i)
    begin
      shift_r <= {data_i, shift_r[WIDTH-1:1]};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      count_r   <= '0;
      payload_o <= DEFAULT;
      new_o     <= 1'b0;
    end
    else
    begin
      new_o <= 1'b0;
      if (en_i)
      begin
        if (!full)
        begin
          count_r <= count_r + 1'b1;
        end
      end
      else
      begin
        // Partial payloads are dropped
        count_r <= '0;
        if (full)
        begin
          payload_o <= payload_t'(shift_r);
          new_o     <= 1'b1;
        end
      end
    end
  end

  a_en_len : assert property (@(posedge clk_i) disable iff (rst_i)
    en_i [*WIDTH] |=> !en_i);

endmodule

// ==== verilog/gw_mem_router.sv ====
`timescale 1ns/100ps

module gw_mem_router
  import gw_cfg_pkg::*;
  import gw_mem_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [CORD_WIDTH-1:0] my_cord_i,
  input  logic [PAGE_WIDTH-1:0] base_page_i,
  input  logic                  cmd_v_i,
  input  gw_mem_cmd_s           cmd_i,
  output logic                  cmd_yumi_o,
  output logic                  resp_v_o,
  output gw_mem_resp_s          resp_o,
  input  logic                  resp_ready_i,
  gw_mem_if.requester           host,
  gw_mem_if.requester           dram
);

  logic outstanding_r;
  logic run_r;
  logic to_host;
  logic open_gate;

  //////////////////////////////
  // Outstanding gate
  //////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      run_r         <= 1'b0;
      outstanding_r <= 1'b0;
    end
    else
    begin
      run_r <= 1'b1;
      if (cmd_yumi_o)
        outstanding_r <= 1'b1;
      else if (resp_v_o && resp_ready_i)
        outstanding_r <= 1'b0;
    end
  end

  assign open_gate = run_r & ~outstanding_r;

  //////////////////////////////
  // Steering by page
  //////////////////////////////

  assign to_host = (cmd_i.addr[ADDR_WIDTH-1 -: PAGE_WIDTH] < base_page_i);

  assign host.cmd_v = cmd_v_i & to_host & open_gate;
  assign dram.cmd_v = cmd_v_i & ~to_host & open_gate;
  assign host.cmd   = cmd_i;
  assign dram.cmd   = cmd_i;
  assign cmd_yumi_o = to_host ? host.cmd_yumi : dram.cmd_yumi;

  // Only one target can hold a response at a time
  assign resp_v_o        = host.resp_v | dram.resp_v;
  assign host.resp_ready = resp_ready_i;
  assign dram.resp_ready = resp_ready_i;

  always_comb
  begin
    resp_o          = host.resp_v ? host.resp : dram.resp;
    resp_o.src_cord = my_cord_i;
  end

  a_gate_closed : assert property (@(posedge clk_i) disable iff (rst_i)
    (host.resp_v || dram.resp_v) |-> !(host.cmd_v || dram.cmd_v));

  a_resp_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_o));

  a_one_resp : assert property (@(posedge clk_i) disable iff (rst_i)
    !(host.resp_v && dram.resp_v));

endmodule

// ==== verilog/gw_host_mmio.sv ====
`timescale 1ns/100ps

module gw_host_mmio
  import gw_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  gw_mem_if.target   bus,
  output logic       finish_o
);

  logic [DATA_WIDTH-1:0]     regs_r [HOST_REGS];
  logic [HOST_IDX_WIDTH-1:0] idx;
  logic                      accept;
  logic                      is_write;
  logic                      resp_v_r;
  logic                      finish_r;
  gw_mem_resp_s              resp_r;

  assign idx      = bus.cmd.addr[HOST_IDX_WIDTH-1:0];
  assign is_write = (bus.cmd.op == GW_OP_WRITE);
  assign accept   = bus.cmd_v & ~resp_v_r;

  always_ff @(posedge clk_i)
  begin
    if (accept && is_write)
      regs_r[idx] <= bus.cmd.data;
    if (accept)
    begin
      resp_r.op       <= bus.cmd.op;
      resp_r.data     <= is_write ? bus.cmd.data : regs_r[idx];
      resp_r.dst_cord <= bus.cmd.src_cord;
      resp_r.src_cord <= '0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      resp_v_r <= 1'b0;
      finish_r <= 1'b0;
    end
    else
    begin
      if (accept)
        resp_v_r <= 1'b1;
      else if (bus.resp_ready)
        resp_v_r <= 1'b0;
      // Program done flag
      if (accept && is_write && idx == HOST_IDX_WIDTH'(HOST_FINISH_REG))
        finish_r <= bus.cmd.data[0];
    end
  end

  assign bus.cmd_yumi = accept;
  assign bus.resp_v   = resp_v_r;
  assign bus.resp     = resp_r;
  assign finish_o     = finish_r;

endmodule

// ==== verilog/gw_dram_model.sv ====
`timescale 1ns/100ps

module gw_dram_model
  import gw_mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  gw_mem_if.target bus
);

  logic [DATA_WIDTH-1:0] mem_r [DRAM_WORDS];
  logic                  accept;

  // Accept stage
  logic                      acc_v_r;
  logic [DRAM_IDX_WIDTH-1:0] acc_idx;
  gw_mem_cmd_s               acc_cmd_r;

  // Output stage
  logic                      out_v_r;
  gw_mem_resp_s              out_r;

  assign accept  = bus.cmd_v & ~acc_v_r & ~out_v_r;
  assign acc_idx = acc_cmd_r.addr[DRAM_IDX_WIDTH-1:0];

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      acc_cmd_r <= bus.cmd;
    end
    // Output stage is always empty when the accept stage holds a command
    if (acc_v_r)
    begin
      if (acc_cmd_r.op == GW_OP_WRITE)
        mem_r[acc_idx] <= acc_cmd_r.data;
      out_r.op       <= acc_cmd_r.op;
      out_r.data     <= (acc_cmd_r.op == GW_OP_WRITE) ? acc_cmd_r.data : mem_r[acc_idx];
      out_r.dst_cord <= acc_cmd_r.src_cord;
      out_r.src_cord <= '0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      acc_v_r <= 1'b0;
      out_v_r <= 1'b0;
    end
    else
    begin
      acc_v_r <= accept;
      if (acc_v_r)
        out_v_r <= 1'b1;
      else if (bus.resp_ready)
        out_v_r <= 1'b0;
    end
  end

  assign bus.cmd_yumi = accept;
  assign bus.resp_v   = out_v_r;
  assign bus.resp     = out_r;

endmodule

// ==== verilog/gw_mem_node.sv ====
`timescale 1ns/100ps

module gw_mem_node
  import gw_cfg_pkg::*;
  import gw_mem_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         tag_data_i,
  input  logic         tag_ctl_en_i,
  input  logic         tag_map_en_i,
  input  logic         cmd_v_i,
  input  gw_mem_cmd_s  cmd_i,
  output logic         cmd_yumi_o,
  output logic         resp_v_o,
  output gw_mem_resp_s resp_o,
  input  logic         resp_ready_i,
  output logic         finish_o
);

  gw_ctl_payload_s ctl_payload;
  gw_map_payload_s map_payload;
  logic            node_rst;

  //////////////////////////////
  // Tag clients
  //////////////////////////////

  gw_tag_client #(
    .payload_t (gw_ctl_payload_s),
    .DEFAULT   (GW_CTL_DEFAULT)
  ) ctl_client (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .en_i      (tag_ctl_en_i),
    .data_i    (tag_data_i),
    .payload_o (ctl_payload),
    .new_o     ()
  );

  gw_tag_client #(
    .payload_t (gw_map_payload_s),
    .DEFAULT   (GW_MAP_DEFAULT)
  ) map_client (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .en_i      (tag_map_en_i),
    .data_i    (tag_data_i),
    .payload_o (map_payload),
    .new_o     ()
  );

  assign node_rst = rst_i | ctl_payload.reset;

  //////////////////////////////
  // Memory side
  //////////////////////////////

  gw_mem_if host_bus ();
  gw_mem_if dram_bus ();

  gw_mem_router router (
    .clk_i        (clk_i),
    .rst_i        (node_rst),
    .my_cord_i    (ctl_payload.cord),
    .base_page_i  (map_payload.base_page),
    .cmd_v_i      (cmd_v_i),
    .cmd_i        (cmd_i),
    .cmd_yumi_o   (cmd_yumi_o),
    .resp_v_o     (resp_v_o),
    .resp_o       (resp_o),
    .resp_ready_i (resp_ready_i),
    .host         (host_bus.requester),
    .dram         (dram_bus.requester)
  );

  gw_host_mmio host_mmio (
    .clk_i    (clk_i),
    .rst_i    (node_rst),
    .bus      (host_bus.target),
    .finish_o (finish_o)
  );

  gw_dram_model dram (
    .clk_i (clk_i),
    .rst_i (node_rst),
    .bus   (dram_bus.target)
  );

endmodule

// ==== test/tb_gw_mem_node.sv ====
`timescale 1ns/100ps

module tb_gw_mem_node
  import gw_cfg_pkg::*;
  import gw_mem_pkg::*;
;

  localparam int CLK_PERIOD     = 8;
  localparam int NUM_PAIRS      = 12;
  localparam int NUM_HOST_READS = 8;
  // Pairs, host fill and reads, map check, two stalled writes, finish
  localparam int NUM_TXN     = 2 * NUM_PAIRS + 4 + NUM_HOST_READS + 2 + 4 + 1;
  localparam int RUN_CYCLES  = 16 + 10 + 3 * 12 + NUM_TXN * 8 + 8 + 50;
  localparam int WATCHDOG_NS = RUN_CYCLES * CLK_PERIOD;

  logic         clk;
  logic         rst;
  logic         tag_data;
  logic         tag_ctl_en;
  logic         tag_map_en;
  logic         cmd_v;
  gw_mem_cmd_s  cmd;
  logic         cmd_yumi;
  logic         resp_v;
  gw_mem_resp_s resp;
  logic         resp_ready;
  logic         finish;

  // Reference model
  logic [DATA_WIDTH-1:0] host_m [HOST_REGS];
  logic [DATA_WIDTH-1:0] dram_m [DRAM_WORDS];
  logic [PAGE_WIDTH-1:0] model_base;
  logic [CORD_WIDTH-1:0] model_cord;
  logic                  node_live;
  gw_mem_op_e            exp_op;
  logic [DATA_WIDTH-1:0] exp_data;
  logic [CORD_WIDTH-1:0] exp_dst;
  logic [31:0]           lcg_state;
  logic                  cmd_seen;
  logic                  resp_seen;
  logic                  xfer_host;
  logic                  xfer_dram;

  gw_mem_node UUT (
    .clk_i        (clk),
    .rst_i        (rst),
    .tag_data_i   (tag_data),
    .tag_ctl_en_i (tag_ctl_en),
    .tag_map_en_i (tag_map_en),
    .cmd_v_i      (cmd_v),
    .cmd_i        (cmd),
    .cmd_yumi_o   (cmd_yumi),
    .resp_v_o     (resp_v),
    .resp_o       (resp),
    .resp_ready_i (resp_ready),
    .finish_o     (finish)
  );

  always
  begin
    #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    cmd_seen  <= cmd_v && cmd_yumi;
    resp_seen <= resp_v && resp_ready;
  end

  assign xfer_host = cmd_v && cmd_yumi && (cmd.addr[ADDR_WIDTH-1 -: PAGE_WIDTH] < model_base);
  assign xfer_dram = cmd_v && cmd_yumi && !(cmd.addr[ADDR_WIDTH-1 -: PAGE_WIDTH] < model_base);

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_held : assert property (@(posedge clk) disable iff (rst)
    !node_live |-> !cmd_yumi && !resp_v && !finish)
    else stop_on_error($sformatf("[FAIL] %0t: node active while held in reset", $time));

  a_host_lat : assert property (@(posedge clk) disable iff (rst)
    xfer_host |=> resp_v)
    else stop_on_error($sformatf("[FAIL] %0t: host response not 1 cycle after command", $time));

  a_dram_early : assert property (@(posedge clk) disable iff (rst)
    xfer_dram |=> !resp_v)
    else stop_on_error($sformatf("[FAIL] %0t: DRAM response 1 cycle after command", $time));

  a_dram_lat : assert property (@(posedge clk) disable iff (rst)
    $past(xfer_dram) |=> resp_v)
    else stop_on_error($sformatf("[FAIL] %0t: DRAM response not 2 cycles after command", $time));

  a_data : assert property (@(posedge clk) disable iff (rst)
    resp_v |-> resp.data == exp_data && resp.op == exp_op)
    else stop_on_error($sformatf("[FAIL] %0t: response data %h, expected %h",
                                 $time, resp.data, exp_data));

  a_cord : assert property (@(posedge clk) disable iff (rst)
    resp_v |-> resp.dst_cord == exp_dst && resp.src_cord == model_cord)
    else stop_on_error($sformatf("[FAIL] %0t: response coordinates wrong", $time));

  a_hold : assert property (@(posedge clk) disable iff (rst)
    resp_v && !resp_ready |=> resp_v && $stable(resp))
    else stop_on_error($sformatf("[FAIL] %0t: stalled response changed", $time));

  a_gate : assert property (@(posedge clk) disable iff (rst)
    resp_v |-> !cmd_yumi)
    else stop_on_error($sformatf("[FAIL] %0t: command taken with response pending", $time));

  a_finish : assert property (@(posedge clk) disable iff (rst)
    xfer_host && cmd.op == GW_OP_WRITE
      && cmd.addr[HOST_IDX_WIDTH-1:0] == HOST_IDX_WIDTH'(HOST_FINISH_REG)
      |=> finish == $past(cmd.data[0]))
    else stop_on_error($sformatf("[FAIL] %0t: finish_o does not follow its register", $time));

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Page drawn from [lo_page, hi_page)
  function automatic logic [ADDR_WIDTH-1:0] rand_addr(input int lo_page, input int hi_page);
    logic [31:0]           r;
    logic [PAGE_WIDTH-1:0] page;
    r    = next_rand();
    page = PAGE_WIDTH'(lo_page + int'(r[31:16]) % (hi_page - lo_page));
    return {page, r[ADDR_WIDTH-PAGE_WIDTH-1:0]};
  endfunction

  task automatic shift_tag(input logic is_ctl, input logic [7:0] value);
    for (int i = 0; i < 8; i++)
    begin
      @(negedge clk);
      tag_data = value[i];
      if (is_ctl)
        tag_ctl_en = 1'b1;
      else
        tag_map_en = 1'b1;
    end
    @(negedge clk);
    tag_ctl_en = 1'b0;
    tag_map_en = 1'b0;
    // Commit edge and one more cycle until the new value is out
    repeat (2) @(negedge clk);
  endtask

  task automatic wait_cmd_xfer();
    do @(negedge clk); while (!cmd_seen);
  endtask

  task automatic wait_resp_xfer();
    do @(negedge clk); while (!resp_seen);
  endtask

  // Stall > 0 holds resp_ready low and presents the same write again
  task automatic run_cmd(input gw_mem_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                         input logic [DATA_WIDTH-1:0] data, input int stall);
    logic [CORD_WIDTH-1:0] src;
    logic                  is_host;
    src     = CORD_WIDTH'(next_rand() >> 20);
    is_host = addr[ADDR_WIDTH-1 -: PAGE_WIDTH] < model_base;
    @(negedge clk);
    exp_op  = op;
    exp_dst = src;
    if (op == GW_OP_WRITE)
    begin
      exp_data = data;
      if (is_host)
        host_m[addr[HOST_IDX_WIDTH-1:0]] = data;
      else
        dram_m[addr[DRAM_IDX_WIDTH-1:0]] = data;
    end
    else
      exp_data = is_host ? host_m[addr[HOST_IDX_WIDTH-1:0]] : dram_m[addr[DRAM_IDX_WIDTH-1:0]];
    cmd.op       = op;
    cmd.addr     = addr;
    cmd.data     = data;
    cmd.src_cord = src;
    cmd_v        = 1'b1;
    if (stall > 0)
      resp_ready = 1'b0;
    wait_cmd_xfer();
    if (stall > 0)
    begin
      while (!resp_v)
        @(negedge clk);
      repeat (stall) @(negedge clk);
      resp_ready = 1'b1;
      wait_resp_xfer();
      wait_cmd_xfer();
    end
    cmd_v = 1'b0;
    wait_resp_xfer();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    logic [ADDR_WIDTH-1:0] addr;
    gw_ctl_payload_s       ctl;
    clk        = 1'b0;
    rst        = 1'b1;
    tag_data   = 1'b0;
    tag_ctl_en = 1'b0;
    tag_map_en = 1'b0;
    cmd_v      = 1'b0;
    cmd        = '0;
    resp_ready = 1'b1;
    cmd_seen   = 1'b0;
    resp_seen  = 1'b0;
    node_live  = 1'b0;
    lcg_state  = 32'h2d6cf640;
    model_base = GW_MAP_DEFAULT.base_page;
    model_cord = '0;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    // Node still held by the control payload
    cmd_v     = 1'b1;
    cmd.op    = GW_OP_WRITE;
    cmd.addr  = rand_addr(8'h80, 256);
    cmd.data  = next_rand();
    repeat (10) @(negedge clk);
    cmd_v = 1'b0;

    shift_tag(1'b0, 8'h40);
    model_base = 8'h40;
    ctl.reset  = 1'b0;
    ctl.cord   = CORD_WIDTH'(next_rand() >> 9) | CORD_WIDTH'(1);
    shift_tag(1'b1, ctl);
    model_cord = ctl.cord;
    node_live  = 1'b1;

    for (int i = 0; i < NUM_PAIRS; i++)
    begin
      addr = rand_addr(8'h40, 256);
      run_cmd(GW_OP_WRITE, addr, next_rand(), 0);
      run_cmd(GW_OP_READ, addr, '0, 0);
    end

    for (int i = 0; i < HOST_REGS; i++)
    begin
      addr = rand_addr(0, 8'h40);
      addr[HOST_IDX_WIDTH-1:0] = HOST_IDX_WIDTH'(i);
      run_cmd(GW_OP_WRITE, addr, next_rand(), 0);
    end
    for (int i = 0; i < NUM_HOST_READS; i++)
      run_cmd(GW_OP_READ, rand_addr(0, 8'h40), '0, 0);

    // Moving the base up sends this DRAM address to the host
    addr = rand_addr(8'h40, 8'h60);
    run_cmd(GW_OP_WRITE, addr, next_rand(), 0);
    shift_tag(1'b0, 8'h60);
    model_base = 8'h60;
    run_cmd(GW_OP_READ, addr, '0, 0);

    run_cmd(GW_OP_WRITE, rand_addr(8'h60, 256), next_rand(), 5);
    run_cmd(GW_OP_WRITE, rand_addr(0, 8'h60), next_rand(), 3);

    run_cmd(GW_OP_WRITE, ADDR_WIDTH'(HOST_FINISH_REG), 32'h1, 0);
    @(negedge clk);
    a_done : assert (finish)
      else stop_on_error($sformatf("[FAIL] %0t: finish_o low after finish write", $time));
    $display("Simulation completed successfully");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    stop_on_error("Watchdog timeout, the test sequence did not complete in time");
  end

endmodule

// ==== filelist.f ====
verilog/gw_cfg_pkg.sv
verilog/gw_mem_pkg.sv
verilog/gw_mem_if.sv
verilog/gw_tag_client.sv
verilog/gw_mem_router.sv
verilog/gw_host_mmio.sv
verilog/gw_dram_model.sv
verilog/gw_mem_node.sv
test/tb_gw_mem_node.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gw_mem_node
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
